/* flist.f */
logic/axi_reflect_pkg.sv
logic/axi_axil_reflect.sv
logic/axil_reg_bank.sv
logic/axi_reflect_top.sv
bench/axi_reflect_tb.sv

/* Makefile */
# Verilator build for the AXI reflect subsystem.
# Any variable can be overridden, e.g. make run TOP=axi_reflect_tb OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= axi_reflect_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SRCS    := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST) $(EXTRA)

# The binary exits non-zero on $fatal, so make fails with the test.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* bench/axi_reflect_stim.txt */
# op addr data strb id user exp_data exp_resp, all hex; exp_data is checked on reads
# C lines add a read in the same cycle: raddr rid ruser rexp_data rexp_resp
W 0000 11223344 f 1 0 00000000 0
R 0000 00000000 0 2 1 11223344 0
W 0004 aabbccdd f 3 2 00000000 0
W 0004 55667788 5 4 3 00000000 0
R 0004 00000000 0 5 0 aa66cc88 0
W 0008 deadbeef 8 6 1 00000000 0
W 0008 12345678 2 7 2 00000000 0
R 0008 00000000 0 8 3 de005600 0
W 003c cafef00d f 9 0 00000000 0
R 003c 00000000 0 a 1 cafef00d 0
W 0040 ffffffff f b 2 00000000 2
R 0040 00000000 0 c 3 00000000 2
R 0000 00000000 0 d 0 11223344 0
W 1004 01010101 f e 1 00000000 2
R 8000 00000000 0 f 2 00000000 2
R 0004 00000000 0 0 3 aa66cc88 0
C 0010 a5a5a5a5 f 1 1 00000000 0 0000 2 2 11223344 0
R 0010 00000000 0 3 0 a5a5a5a5 0
C 0014 0000ff00 2 4 3 00000000 0 0004 5 1 aa66cc88 0
C 0044 12345678 f 6 0 00000000 2 003c 7 3 cafef00d 0
C 0018 87654321 3 8 2 00000000 0 0050 9 1 00000000 2
R 0018 00000000 0 a 0 00004321 0
R 0014 00000000 0 b 1 0000ff00 0
R 0004 00000000 0 c 2 aa66cc88 0
W 0020 ffffffff 0 d 3 00000000 0
R 0020 00000000 0 e 0 00000000 0

/* bench/axi_reflect_tb.sv */
`timescale 1ns/1ps

module axi_reflect_tb
  import axi_reflect_pkg::*;
();

  localparam STIM_FILE        = "bench/axi_reflect_stim.txt";
  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 16;
  localparam int LINE_CYCLES  = 200;

  // One stimulus line. The r fields are filled for C lines only.
  typedef struct packed {
    logic [7:0] op;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    id_t        id;
    user_t      user;
    data_t      exp_data;
    resp_t      exp_resp;
    addr_t      raddr;
    id_t        rid;
    user_t      ruser;
    data_t      rexp_data;
    resp_t      rexp_resp;
  } stim_t;

  logic    clk;
  logic    rst_n;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready;

  // Handshake flags for the rising edge just past.
  logic    aw_fire;
  logic    w_fire;
  logic    ar_fire;
  logic    b_fire;
  logic    r_fire;
  axi_b_t  b_seen;
  axi_r_t  r_seen;
  logic    b_stall;
  logic    r_stall;
  axi_b_t  b_prev;
  axi_r_t  r_prev;

  stim_t   stim_q[$];
  logic    loaded = 1'b0;
  int      seed = 80;
  int      rnd;

  axi_reflect_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

  always #(CLK_HALF) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Run aborted.");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("error: %s got %0h expected %0h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------------------
  // Monitors.
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    aw_fire <= aw_valid && aw_ready;
    w_fire  <= w_valid && w_ready;
    ar_fire <= ar_valid && ar_ready;
    b_fire  <= b_valid && b_ready;
    r_fire  <= r_valid && r_ready;
    if (b_valid && b_ready) begin
      b_seen <= b;
    end
    if (r_valid && r_ready) begin
      r_seen <= r;
    end
  end

  // A response refused at the last edge must stay as it was.
  // Its address channel stays closed meanwhile.
  always @(posedge clk) begin
    if (b_stall) begin
      check_value("b_valid", 64'(b_valid), 64'(1'b1));
      check_value("b", 64'(b), 64'(b_prev));
      check_value("aw_ready", 64'(aw_ready), 64'(1'b0));
    end
    if (r_stall) begin
      check_value("r_valid", 64'(r_valid), 64'(1'b1));
      check_value("r", 64'(r), 64'(r_prev));
      check_value("ar_ready", 64'(ar_ready), 64'(1'b0));
    end
    b_stall <= rst_n && b_valid && !b_ready;
    r_stall <= rst_n && r_valid && !r_ready;
    b_prev  <= b;
    r_prev  <= r;
  end

  // Random back-pressure on the response channels.
  always @(negedge clk) begin
    if (!rst_n) begin
      b_ready = 1'b0;
      r_ready = 1'b0;
    end else begin
      rnd = $random(seed);
      b_ready = rnd[0];
      r_ready = rnd[1];
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus.
  // ------------------------------------------------------------------------
  task automatic load_stim();
    int               fd;
    int               code;
    logic [7:0]       op;
    logic [31:0]      fld [12];
    logic [8*128-1:0] line_buf;
    stim_t            entry;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("Cannot open the stimulus file %s", STIM_FILE));
    end else begin
      code = $fscanf(fd, "%s", op);
      while (code == 1) begin
        if (op == "#") begin
          code = $fgets(line_buf, fd);
        end else if (op != "W" && op != "R" && op != "C") begin
          abort_run($sformatf("Unknown operation %s in the stimulus file", op));
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3],
                         fld[4], fld[5], fld[6]);
          if (op == "C") begin
            code = code + $fscanf(fd, "%h %h %h %h %h", fld[7], fld[8], fld[9],
                                  fld[10], fld[11]);
          end
          if (code != ((op == "C") ? 12 : 7)) begin
            abort_run("A stimulus line has missing or unreadable fields");
          end else begin
            entry          = '0;
            entry.op       = op;
            entry.addr     = addr_t'(fld[0]);
            entry.data     = data_t'(fld[1]);
            entry.strb     = strb_t'(fld[2]);
            entry.id       = id_t'(fld[3]);
            entry.user     = user_t'(fld[4]);
            entry.exp_data = data_t'(fld[5]);
            entry.exp_resp = resp_t'(fld[6]);
            if (op == "C") begin
              entry.raddr     = addr_t'(fld[7]);
              entry.rid       = id_t'(fld[8]);
              entry.ruser     = user_t'(fld[9]);
              entry.rexp_data = data_t'(fld[10]);
              entry.rexp_resp = resp_t'(fld[11]);
            end
            stim_q.push_back(entry);
          end
        end
        code = $fscanf(fd, "%s", op);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_write(input addr_t addr, input data_t data, input strb_t strb,
                           input id_t id, input user_t user, input resp_t exp_resp);
    logic aw_done;
    logic w_done;
    aw_done  = 1'b0;
    w_done   = 1'b0;
    aw.addr  = addr;
    aw.id    = id;
    aw.len   = '0;
    aw.size  = 3'd2;
    aw.burst = 2'b01;
    aw.user  = user;
    aw_valid = 1'b1;
    w.data   = data;
    w.strb   = strb;
    w.last   = 1'b1;
    w_valid  = 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      if (aw_fire) begin
        aw_valid = 1'b0;
        aw_done  = 1'b1;
      end
      if (w_fire) begin
        w_valid = 1'b0;
        w_done  = 1'b1;
      end
    end
    do begin
      @(negedge clk);
    end while (!b_fire);
    check_value("b.id", 64'(b_seen.id), 64'(id));
    check_value("b.user", 64'(b_seen.user), 64'(user));
    check_value("b.resp", 64'(b_seen.resp), 64'(exp_resp));
  endtask

  task automatic run_read(input addr_t addr, input id_t id, input user_t user,
                          input data_t exp_data, input resp_t exp_resp);
    ar.addr  = addr;
    ar.id    = id;
    ar.len   = '0;
    ar.size  = 3'd2;
    ar.burst = 2'b01;
    ar.user  = user;
    ar_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!ar_fire);
    ar_valid = 1'b0;
    do begin
      @(negedge clk);
    end while (!r_fire);
    check_value("r.id", 64'(r_seen.id), 64'(id));
    check_value("r.user", 64'(r_seen.user), 64'(user));
    check_value("r.data", 64'(r_seen.data), 64'(exp_data));
    check_value("r.resp", 64'(r_seen.resp), 64'(exp_resp));
    check_value("r.last", 64'(r_seen.last), 64'(1'b1));
  endtask

  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (stim_q.size() * LINE_CYCLES + RESET_CYCLES) * 2 * CLK_HALF;
    #(limit_ns);
    abort_run($sformatf("Timeout, the run did not finish within %0d ns", limit_ns));
  end

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    load_stim();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle state after reset.
    check_value("b_valid", 64'(b_valid), 64'(1'b0));
    check_value("r_valid", 64'(r_valid), 64'(1'b0));
    check_value("aw_ready", 64'(aw_ready), 64'(1'b1));
    check_value("w_ready", 64'(w_ready), 64'(1'b0));
    check_value("ar_ready", 64'(ar_ready), 64'(1'b1));

    foreach (stim_q[i]) begin
      if (stim_q[i].op == "W") begin
        run_write(stim_q[i].addr, stim_q[i].data, stim_q[i].strb, stim_q[i].id,
                  stim_q[i].user, stim_q[i].exp_resp);
      end else if (stim_q[i].op == "R") begin
        run_read(stim_q[i].addr, stim_q[i].id, stim_q[i].user, stim_q[i].exp_data,
                 stim_q[i].exp_resp);
      end else begin
        // Write and read issued in the same cycle.
        fork
          run_write(stim_q[i].addr, stim_q[i].data, stim_q[i].strb, stim_q[i].id,
                    stim_q[i].user, stim_q[i].exp_resp);
          run_read(stim_q[i].raddr, stim_q[i].rid, stim_q[i].ruser,
                   stim_q[i].rexp_data, stim_q[i].rexp_resp);
        join
      end
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* logic/axi_reflect_top.sv */
`timescale 1ns/1ps

module axi_reflect_top
  import axi_reflect_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  input  axi_aw_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready,
  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready
);

  // AXI-Lite link between bridge and bank.
  addr_t   axil_aw_addr;
  logic    axil_aw_valid;
  logic    axil_aw_ready;
  axil_w_t axil_w;
  logic    axil_w_valid;
  logic    axil_w_ready;
  axil_b_t axil_b;
  logic    axil_b_valid;
  logic    axil_b_ready;
  addr_t   axil_ar_addr;
  logic    axil_ar_valid;
  logic    axil_ar_ready;
  axil_r_t axil_r;
  logic    axil_r_valid;
  logic    axil_r_ready;

  axi_axil_reflect u_reflect (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b             (b),
    .b_valid       (b_valid),
    .b_ready       (b_ready),
    .ar            (ar),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r             (r),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .axil_aw_addr  (axil_aw_addr),
    .axil_aw_valid (axil_aw_valid),
    .axil_aw_ready (axil_aw_ready),
    .axil_w        (axil_w),
    .axil_w_valid  (axil_w_valid),
    .axil_w_ready  (axil_w_ready),
    .axil_b        (axil_b),
    .axil_b_valid  (axil_b_valid),
    .axil_b_ready  (axil_b_ready),
    .axil_ar_addr  (axil_ar_addr),
    .axil_ar_valid (axil_ar_valid),
    .axil_ar_ready (axil_ar_ready),
    .axil_r        (axil_r),
    .axil_r_valid  (axil_r_valid),
    .axil_r_ready  (axil_r_ready)
  );

  axil_reg_bank u_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_addr  (axil_aw_addr),
    .aw_valid (axil_aw_valid),
    .aw_ready (axil_aw_ready),
    .w        (axil_w),
    .w_valid  (axil_w_valid),
    .w_ready  (axil_w_ready),
    .b        (axil_b),
    .b_valid  (axil_b_valid),
    .b_ready  (axil_b_ready),
    .ar_addr  (axil_ar_addr),
    .ar_valid (axil_ar_valid),
    .ar_ready (axil_ar_ready),
    .r        (axil_r),
    .r_valid  (axil_r_valid),
    .r_ready  (axil_r_ready)
  );

endmodule

/* logic/axil_reg_bank.sv */
`timescale 1ns/1ps

module axil_reg_bank
  import axi_reflect_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  input  addr_t   aw_addr,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axil_w_t w,
  input  logic    w_valid,
  output logic    w_ready,
  output axil_b_t b,
  output logic    b_valid,
  input  logic    b_ready,

  input  addr_t   ar_addr,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axil_r_t r,
  output logic    r_valid,
  input  logic    r_ready
);

  data_t regs [REG_COUNT];

  logic                 wr_go;
  logic                 rd_go;
  logic [REG_IDX_W-1:0] wr_idx;
  logic [REG_IDX_W-1:0] rd_idx;
  logic                 wr_hit;
  logic                 rd_hit;

  // Register index from word address bits.
  function automatic logic [REG_IDX_W-1:0] reg_index(addr_t addr);
    return addr[REG_IDX_W+1:2];
  endfunction

  // Anything above the bank window is out of range.
  function automatic logic in_range(addr_t addr);
    return addr[ADDR_W-1:REG_IDX_W+2] == '0;
  endfunction

  assign wr_idx = reg_index(aw_addr);
  assign rd_idx = reg_index(ar_addr);
  assign wr_hit = in_range(aw_addr);
  assign rd_hit = in_range(ar_addr);

  // ------------------------------------------------------------------------
  // Write path.
  // ------------------------------------------------------------------------
  // AW and W are taken together, one B outstanding.
  assign wr_go    = aw_valid && w_valid && !b_valid;
  assign aw_ready = wr_go;
  assign w_ready  = wr_go;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_valid <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_go) begin
        b_valid <= 1'b1;
        if (wr_hit) begin
          for (int i = 0; i < STRB_W; i++) begin
            if (w.strb[i]) begin
              regs[wr_idx][i*8 +: 8] <= w.data[i*8 +: 8];
            end
          end
        end
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      b.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ------------------------------------------------------------------------
  // Read path.
  // ------------------------------------------------------------------------
  assign ar_ready = !r_valid;
  assign rd_go    = ar_valid && ar_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
    end else if (rd_go) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // Out of range reads return zero.
  always_ff @(posedge clk) begin
    if (rd_go) begin
      r.data <= rd_hit ? regs[rd_idx] : '0;
      r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

/* logic/axi_axil_reflect.sv */
`timescale 1ns/1ps

module axi_axil_reflect
  import axi_reflect_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  input  axi_aw_t aw,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_w_t  w,
  input  logic    w_valid,
  output logic    w_ready,
  output axi_b_t  b,
  output logic    b_valid,
  input  logic    b_ready,
  input  axi_ar_t ar,
  input  logic    ar_valid,
  output logic    ar_ready,
  output axi_r_t  r,
  output logic    r_valid,
  input  logic    r_ready,

  output addr_t   axil_aw_addr,
  output logic    axil_aw_valid,
  input  logic    axil_aw_ready,
  output axil_w_t axil_w,
  output logic    axil_w_valid,
  input  logic    axil_w_ready,
  input  axil_b_t axil_b,
  input  logic    axil_b_valid,
  output logic    axil_b_ready,
  output addr_t   axil_ar_addr,
  output logic    axil_ar_valid,
  input  logic    axil_ar_ready,
  input  axil_r_t axil_r,
  input  logic    axil_r_valid,
  output logic    axil_r_ready
);

  // ------------------------------------------------------------------------
  // Write direction.
  // ------------------------------------------------------------------------
  wr_state_t wr_state;
  addr_t     wr_addr;
  id_t       wr_id;
  user_t     wr_user;
  axil_w_t   wr_beat;
  resp_t     wr_resp;
  logic      lite_aw_done;
  logic      lite_w_done;
  logic      lite_aw_xfer;
  logic      lite_w_xfer;

  assign aw_ready      = (wr_state == WR_IDLE);
  assign w_ready       = (wr_state == WR_DATA);
  assign axil_aw_valid = (wr_state == WR_LITE) && !lite_aw_done;
  assign axil_w_valid  = (wr_state == WR_LITE) && !lite_w_done;
  assign axil_b_ready  = (wr_state == WR_WAIT);
  assign b_valid       = (wr_state == WR_RESP);
  assign axil_aw_addr  = wr_addr;
  assign axil_w        = wr_beat;
  assign lite_aw_xfer  = axil_aw_valid && axil_aw_ready;
  assign lite_w_xfer   = axil_w_valid && axil_w_ready;

  // Reflect the held ID and USER.
  always_comb begin
    b.id   = wr_id;
    b.resp = wr_resp;
    b.user = wr_user;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state     <= WR_IDLE;
      lite_aw_done <= 1'b0;
      lite_w_done  <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (aw_valid) begin
            wr_state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_valid) begin
            wr_state <= WR_LITE;
          end
        end
        WR_LITE: begin
          if (lite_aw_xfer) begin
            lite_aw_done <= 1'b1;
          end
          if (lite_w_xfer) begin
            lite_w_done <= 1'b1;
          end
          // Both lite channels done, possibly in different cycles.
          if ((lite_aw_done || lite_aw_xfer) && (lite_w_done || lite_w_xfer)) begin
            lite_aw_done <= 1'b0;
            lite_w_done  <= 1'b0;
            wr_state     <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          if (axil_b_valid) begin
            wr_state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_ready) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      wr_addr <= aw.addr;
      wr_id   <= aw.id;
      wr_user <= aw.user;
    end
    if (w_valid && w_ready) begin
      wr_beat.data <= w.data;
      wr_beat.strb <= w.strb;
    end
    if (axil_b_valid && axil_b_ready) begin
      wr_resp <= axil_b.resp;
    end
  end

  // ------------------------------------------------------------------------
  // Read direction.
  // ------------------------------------------------------------------------
  rd_state_t rd_state;
  addr_t     rd_addr;
  id_t       rd_id;
  user_t     rd_user;
  axil_r_t   rd_beat;

  assign ar_ready      = (rd_state == RD_IDLE);
  assign axil_ar_valid = (rd_state == RD_LITE);
  assign axil_r_ready  = (rd_state == RD_WAIT);
  assign r_valid       = (rd_state == RD_RESP);
  assign axil_ar_addr  = rd_addr;

  // Single beat only, so last is always set.
  always_comb begin
    r.id   = rd_id;
    r.data = rd_beat.data;
    r.resp = rd_beat.resp;
    r.user = rd_user;
    r.last = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (ar_valid) begin
            rd_state <= RD_LITE;
          end
        end
        RD_LITE: begin
          if (axil_ar_ready) begin
            rd_state <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (axil_r_valid) begin
            rd_state <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (r_ready) begin
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      rd_addr <= ar.addr;
      rd_id   <= ar.id;
      rd_user <= ar.user;
    end
    if (axil_r_valid && axil_r_ready) begin
      rd_beat <= axil_r;
    end
  end

endmodule

/* logic/axi_reflect_pkg.sv */
package axi_reflect_pkg;

  // ------------------------------------------------------------------------
  // Widths.
  // ------------------------------------------------------------------------
  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int ID_W      = 4;
  localparam int USER_W    = 2;
  localparam int REG_COUNT = 16;
  localparam int REG_IDX_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [USER_W-1:0] user_t;
  typedef logic [1:0]        resp_t;
  typedef logic [7:0]        len_t;
  typedef logic [2:0]        size_t;
  typedef logic [1:0]        burst_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // ------------------------------------------------------------------------
  // Channel payloads.
  // ------------------------------------------------------------------------
  typedef struct packed {
    addr_t  addr;
    id_t    id;
    len_t   len;
    size_t  size;
    burst_t burst;
    user_t  user;
  } axi_aw_t;

  typedef struct packed {
    addr_t  addr;
    id_t    id;
    len_t   len;
    size_t  size;
    burst_t burst;
    user_t  user;
  } axi_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
    user_t user;
  } axi_b_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    user_t user;
    logic  last;
  } axi_r_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  typedef struct packed {
    resp_t resp;
  } axil_b_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } axil_r_t;

  // Bridge FSM states.
  typedef enum logic [2:0] {
    WR_IDLE,
    WR_DATA,
    WR_LITE,
    WR_WAIT,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LITE,
    RD_WAIT,
    RD_RESP
  } rd_state_t;

endpackage
